//--- source/isp_dpc_pkg.sv
package isp_dpc_pkg;

	// raw sample width
	localparam int PIX_BITS = 8;
	typedef logic [PIX_BITS-1:0] pixel_t;

	// centre minus neighbour, one extra bit for the sign
	typedef logic signed [PIX_BITS:0] diff_t;

	// short lines for quick simulation, any width of 6 or more works
	localparam int LINE_WIDTH = 16;
	localparam int COL_BITS = $clog2(LINE_WIDTH);
	typedef logic [COL_BITS-1:0] col_t;

	// lines of history for a 5x5 window
	localparam int BUF_LINES = 4;

	// colour at the window centre
	// bit 1 follows line parity, bit 0 pixel parity
	typedef enum logic [1:0] {
		PHASE_R  = 2'd0,
		PHASE_GR = 2'd1,
		PHASE_GB = 2'd2,
		PHASE_B  = 2'd3
	} cfa_phase_t;

	// colour of the first pixel of a frame
	localparam cfa_phase_t BAYER_ORDER = PHASE_R;

	// in_href to out_href, in clocks
	localparam int DPC_LATENCY = 8;
endpackage

//--- source/dpc_window_if.sv
`timescale 1ns/1ps

// nine same-colour pixels, row-major, nb5 is the centre
interface dpc_window_if
	import isp_dpc_pkg::*;
();
	pixel_t nb1;
	pixel_t nb2;
	pixel_t nb3;
	pixel_t nb4;
	pixel_t nb5;
	pixel_t nb6;
	pixel_t nb7;
	pixel_t nb8;
	pixel_t nb9;

	// window builder side
	modport src (output nb1, nb2, nb3, nb4, nb5, nb6, nb7, nb8, nb9);

	// median and detect side, read only
	modport sink (input nb1, nb2, nb3, nb4, nb5, nb6, nb7, nb8, nb9);
endinterface

//--- source/dpc_line_buffer.sv
`timescale 1ns/1ps

module dpc_line_buffer
	import isp_dpc_pkg::*;
(
	input  logic   pclk,
	input  logic   rst_n,
	input  logic   in_href,
	input  pixel_t in_raw,
	output pixel_t tap1,
	output pixel_t tap2,
	output pixel_t tap3,
	output pixel_t tap4
);
	col_t   col;
	col_t   rd_col;
	pixel_t mem [BUF_LINES][LINE_WIDTH];
	pixel_t wr_data [BUF_LINES];
	pixel_t tap_q [BUF_LINES];

	// column of the pixel on in_raw
	// held at zero between lines, so each line starts at column 0
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
		end else if (!in_href || col == col_t'(LINE_WIDTH - 1)) begin
			col <= '0;
		end else begin
			col <= col + 1'b1;
		end
	end

	// read one column ahead so the tap is ready with its pixel
	assign rd_col = (in_href && col != col_t'(LINE_WIDTH - 1)) ? col + 1'b1 : '0;

	// cascade, first line stores the live pixel, each later one the tap before it
	always_comb begin
		wr_data[0] = in_raw;
		for (int i = 1; i < BUF_LINES; i++) begin
			wr_data[i] = tap_q[i-1];
		end
	end

	// written only on active pixels, read every clock
	always_ff @(posedge pclk) begin
		for (int i = 0; i < BUF_LINES; i++) begin
			if (in_href) begin
				mem[i][col] <= wr_data[i];
			end
			tap_q[i] <= mem[i][rd_col];
		end
	end

	// tap1 one line back, tap4 four lines back
	assign tap1 = tap_q[0];
	assign tap2 = tap_q[1];
	assign tap3 = tap_q[2];
	assign tap4 = tap_q[3];
endmodule

//--- source/dpc_window.sv
`timescale 1ns/1ps

module dpc_window
	import isp_dpc_pkg::*;
(
	input  logic   pclk,
	input  logic   rst_n,
	input  logic   in_href,
	input  logic   in_vsync,
	input  pixel_t in_raw,
	input  pixel_t tap1,
	input  pixel_t tap2,
	input  pixel_t tap3,
	input  pixel_t tap4,
	dpc_window_if.src win
);
	// newest column, top row oldest line
	pixel_t     col_in [5];
	// p[row][col], col 4 newest, centre at p[2][2]
	pixel_t     p [5][5];
	logic       pix_odd;
	logic       line_odd;
	logic       href_d;
	cfa_phase_t phase_in;
	cfa_phase_t phase_c;

	// column register and 5x5 shift array, one column per clock
	always_ff @(posedge pclk) begin
		col_in[0] <= tap4;
		col_in[1] <= tap3;
		col_in[2] <= tap2;
		col_in[3] <= tap1;
		col_in[4] <= in_raw;
		for (int r = 0; r < 5; r++) begin
			for (int c = 0; c < 4; c++) begin
				p[r][c] <= p[r][c+1];
			end
			p[r][4] <= col_in[r];
		end
	end

	// pixel and line parity of the incoming sample
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			href_d   <= 1'b0;
			pix_odd  <= 1'b0;
			line_odd <= 1'b0;
			phase_in <= PHASE_R;
			phase_c  <= PHASE_R;
		end else begin
			href_d  <= in_href;
			pix_odd <= in_href ? ~pix_odd : 1'b0;
			if (in_vsync) begin
				line_odd <= 1'b0;
			end else if (href_d && !in_href) begin
				line_odd <= ~line_odd;
			end
			// centre is two rows and two columns back, same parity as the sample
			// so the phase rides along with the column register, then the array
			phase_in <= cfa_phase_t'(BAYER_ORDER ^ {line_odd, pix_odd});
			phase_c  <= phase_in;
		end
	end

	// same-colour neighbours of the centre
	always_ff @(posedge pclk) begin
		win.nb2 <= p[0][2];
		win.nb4 <= p[2][0];
		win.nb5 <= p[2][2];
		win.nb6 <= p[2][4];
		win.nb8 <= p[4][2];
		case (phase_c)
			// green, nearest diagonals instead of the far corners
			PHASE_GR, PHASE_GB: begin
				win.nb1 <= p[1][1];
				win.nb3 <= p[1][3];
				win.nb7 <= p[3][1];
				win.nb9 <= p[3][3];
			end
			// red or blue, corners two pixels away
			default: begin
				win.nb1 <= p[0][0];
				win.nb3 <= p[0][4];
				win.nb7 <= p[4][0];
				win.nb9 <= p[4][4];
			end
		endcase
	end
endmodule

//--- source/dpc_median.sv
`timescale 1ns/1ps

module dpc_median
	import isp_dpc_pkg::*;
(
	input  logic   pclk,
	input  logic   rst_n,
	dpc_window_if.sink win,
	output pixel_t median
);
	pixel_t row_min [3];
	pixel_t row_med [3];
	pixel_t row_max [3];
	pixel_t max_of_min;
	pixel_t med_of_med;
	pixel_t min_of_max;
	pixel_t med_final;

	function automatic pixel_t min3(input pixel_t a, input pixel_t b, input pixel_t c);
		return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
	endfunction

	function automatic pixel_t max3(input pixel_t a, input pixel_t b, input pixel_t c);
		return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
	endfunction

	function automatic pixel_t med3(input pixel_t a, input pixel_t b, input pixel_t c);
		if (a < b) begin
			return (b < c) ? b : ((a < c) ? c : a);
		end
		return (b > c) ? b : ((a > c) ? c : a);
	endfunction

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			row_min    <= '{default: '0};
			row_med    <= '{default: '0};
			row_max    <= '{default: '0};
			max_of_min <= '0;
			med_of_med <= '0;
			min_of_max <= '0;
			med_final  <= '0;
			median     <= '0;
		end else begin
			// sort each row of three
			row_min[0] <= min3(win.nb1, win.nb2, win.nb3);
			row_med[0] <= med3(win.nb1, win.nb2, win.nb3);
			row_max[0] <= max3(win.nb1, win.nb2, win.nb3);
			row_min[1] <= min3(win.nb4, win.nb5, win.nb6);
			row_med[1] <= med3(win.nb4, win.nb5, win.nb6);
			row_max[1] <= max3(win.nb4, win.nb5, win.nb6);
			row_min[2] <= min3(win.nb7, win.nb8, win.nb9);
			row_med[2] <= med3(win.nb7, win.nb8, win.nb9);
			row_max[2] <= max3(win.nb7, win.nb8, win.nb9);
			// combine across rows
			max_of_min <= max3(row_min[0], row_min[1], row_min[2]);
			med_of_med <= med3(row_med[0], row_med[1], row_med[2]);
			min_of_max <= min3(row_max[0], row_max[1], row_max[2]);
			med_final  <= med3(max_of_min, med_of_med, min_of_max);
			// lines up with the defect flag in dpc_detect
			median     <= med_final;
		end
	end
endmodule

//--- source/dpc_detect.sv
`timescale 1ns/1ps

module dpc_detect
	import isp_dpc_pkg::*;
(
	input  logic   pclk,
	input  logic   rst_n,
	input  pixel_t threshold,
	dpc_window_if.sink win,
	input  pixel_t median,
	output pixel_t corrected
);
	pixel_t     nbr [8];
	diff_t      diff [8];
	pixel_t     abs_diff [8];
	logic [7:0] signs;
	logic       all_over;
	logic       same_sign;
	logic       flag5;
	logic       flag6;
	pixel_t     centre3;
	pixel_t     centre4;
	pixel_t     centre5;
	pixel_t     centre6;

	// the eight neighbours, centre left out
	always_comb begin
		nbr[0] = win.nb1;
		nbr[1] = win.nb2;
		nbr[2] = win.nb3;
		nbr[3] = win.nb4;
		nbr[4] = win.nb6;
		nbr[5] = win.nb7;
		nbr[6] = win.nb8;
		nbr[7] = win.nb9;
	end

	// sign bits, zero difference reads as non-negative
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			signs[i] = diff[i][PIX_BITS];
		end
	end

	// strictly above threshold on every side
	always_comb begin
		all_over = 1'b1;
		for (int i = 0; i < 8; i++) begin
			all_over = all_over & (abs_diff[i] > threshold);
		end
	end

	// difference, magnitude and centre pipeline
	always_ff @(posedge pclk) begin
		for (int i = 0; i < 8; i++) begin
			diff[i]     <= diff_t'({1'b0, win.nb5}) - diff_t'({1'b0, nbr[i]});
			abs_diff[i] <= signs[i] ? pixel_t'(-diff[i]) : pixel_t'(diff[i]);
		end
		centre3 <= win.nb5;
		centre4 <= centre3;
		centre5 <= centre4;
		centre6 <= centre5;
	end

	// defect decision, held one extra stage to meet the median
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			same_sign <= 1'b0;
			flag5     <= 1'b0;
			flag6     <= 1'b0;
		end else begin
			same_sign <= (&signs) | ~(|signs);
			flag5     <= same_sign & all_over;
			flag6     <= flag5;
		end
	end

	assign corrected = flag6 ? median : centre6;
endmodule

//--- source/isp_dpc.sv
`timescale 1ns/1ps

module isp_dpc
	import isp_dpc_pkg::*;
(
	input  logic   pclk,
	input  logic   rst_n,
	input  pixel_t threshold,
	input  logic   in_href,
	input  logic   in_vsync,
	input  pixel_t in_raw,
	output logic   out_href,
	output logic   out_vsync,
	output pixel_t out_raw
);
	pixel_t                 tap1;
	pixel_t                 tap2;
	pixel_t                 tap3;
	pixel_t                 tap4;
	pixel_t                 median;
	pixel_t                 corrected;
	pixel_t                 raw_q;
	logic [DPC_LATENCY-1:0] href_dly;
	logic [DPC_LATENCY-1:0] vsync_dly;

	dpc_window_if win_if ();

	// four previous lines at the current column
	dpc_line_buffer u_line_buffer (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.in_href (in_href),
		.in_raw  (in_raw),
		.tap1    (tap1),
		.tap2    (tap2),
		.tap3    (tap3),
		.tap4    (tap4)
	);

	dpc_window u_window (
		.pclk     (pclk),
		.rst_n    (rst_n),
		.in_href  (in_href),
		.in_vsync (in_vsync),
		.in_raw   (in_raw),
		.tap1     (tap1),
		.tap2     (tap2),
		.tap3     (tap3),
		.tap4     (tap4),
		.win      (win_if.src)
	);

	dpc_median u_median (
		.pclk   (pclk),
		.rst_n  (rst_n),
		.win    (win_if.sink),
		.median (median)
	);

	dpc_detect u_detect (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.threshold (threshold),
		.win       (win_if.sink),
		.median    (median),
		.corrected (corrected)
	);

	// strobes delayed to match the pixel path
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			href_dly  <= '0;
			vsync_dly <= '0;
		end else begin
			href_dly  <= {href_dly[DPC_LATENCY-2:0], in_href};
			vsync_dly <= {vsync_dly[DPC_LATENCY-2:0], in_vsync};
		end
	end

	// last pixel stage, lands with out_href
	always_ff @(posedge pclk) begin
		raw_q <= corrected;
	end

	assign out_href  = href_dly[DPC_LATENCY-1];
	assign out_vsync = vsync_dly[DPC_LATENCY-1];
	// blanked outside active lines
	assign out_raw   = out_href ? raw_q : '0;
endmodule

//--- bench/dpc_ref_model.svh
`ifndef DPC_REF_MODEL_SVH
`define DPC_REF_MODEL_SVH

// frame patterns for the stimulus table
localparam int PAT_FLAT  = 0;
localparam int PAT_RAMP  = 1;
localparam int PAT_NOISE = 2;

function automatic int min2(input int a, input int b);
	return (a < b) ? a : b;
endfunction

function automatic int max2(input int a, input int b);
	return (a > b) ? a : b;
endfunction

// middle of three as the sum minus both extremes
function automatic int mid3(input int a, input int b, input int c);
	return a + b + c - min2(min2(a, b), c) - max2(max2(a, b), c);
endfunction

// fill the frame and drop in the spikes
function automatic void build_frame(input int pat, input int base, input int dy, input int dx,
		input int dval);
	int y0;
	int x0;
	for (int y = 0; y < FRAME_LINES; y++) begin
		for (int x = 0; x < LINE_WIDTH; x++) begin
			// ramp banded by line pairs so no difference is zero
			case (pat)
				PAT_RAMP: frame[y][x] = base + 12 * x + 40 * ((y / 2) % 2);
				PAT_NOISE: frame[y][x] = base + int'($urandom_range(31, 0));
				default: frame[y][x] = base;
			endcase
		end
	end
	// one spike per colour phase inside the checked area
	if (pat == PAT_NOISE) begin
		for (int ph = 0; ph < 4; ph++) begin
			y0 = 2 + 2 * int'($urandom_range(3, 0)) + ph / 2;
			x0 = 2 + 2 * int'($urandom_range(5, 0)) + ph % 2;
			frame[y0][x0] = ($urandom_range(1, 0) == 1) ? 250 : 5;
		end
	end
	if (dy >= 0) begin
		frame[dy][dx] = dval;
	end
endfunction

// corrected value of frame[y][x] as centre of its window
function automatic int expected_pixel(input int y, input int x, input int thr);
	int nb [9];
	int lo [3];
	int md [3];
	int hi [3];
	int phase;
	int step;
	int d;
	int neg;
	int pos;
	bit over;
	phase = int'(BAYER_ORDER) ^ ((y % 2) * 2 + (x % 2));
	// 3x3 grid in row-major order
	// green corners pulled in to the nearest diagonals
	for (int i = 0; i < 9; i++) begin
		step = ((phase == 1 || phase == 2) && i % 2 == 0 && i != 4) ? 1 : 2;
		nb[i] = frame[y + (i / 3 - 1) * step][x + (i % 3 - 1) * step];
	end
	neg = 0;
	pos = 0;
	over = 1'b1;
	for (int i = 0; i < 9; i++) begin
		if (i != 4) begin
			d = nb[4] - nb[i];
			// zero counts as non-negative
			if (d < 0) begin
				neg++;
			end else begin
				pos++;
			end
			if ((d < 0 ? -d : d) <= thr) begin
				over = 1'b0;
			end
		end
	end
	if (!over || (neg != 0 && pos != 0)) begin
		return nb[4];
	end
	// median of medians
	for (int r = 0; r < 3; r++) begin
		lo[r] = min2(min2(nb[3*r], nb[3*r+1]), nb[3*r+2]);
		md[r] = mid3(nb[3*r], nb[3*r+1], nb[3*r+2]);
		hi[r] = max2(max2(nb[3*r], nb[3*r+1]), nb[3*r+2]);
	end
	return mid3(max2(max2(lo[0], lo[1]), lo[2]), mid3(md[0], md[1], md[2]),
		min2(min2(hi[0], hi[1]), hi[2]));
endfunction

`endif

//--- bench/tb_isp_dpc.sv
`timescale 1ns/1ps

module tb_isp_dpc
	import isp_dpc_pkg::*;
();
	localparam int FRAME_LINES = 12;
	localparam int GAP_CYCLES = 6;
	localparam int NUM_TESTS = 9;
	// threshold step and vsync lead-in plus all lines with their gaps
	localparam int FRAME_CYCLES = 4 + FRAME_LINES * (LINE_WIDTH + GAP_CYCLES);
	localparam int TIMEOUT_CYCLES = 8 + NUM_TESTS * (FRAME_CYCLES + DPC_LATENCY + 16);

	logic   pclk;
	logic   rst_n;
	pixel_t threshold;
	logic   in_href;
	logic   in_vsync;
	pixel_t in_raw;
	logic   out_href;
	logic   out_vsync;
	pixel_t out_raw;

	int frame [FRAME_LINES][LINE_WIDTH];
	int captured [FRAME_LINES][LINE_WIDTH];
	int out_lines = 0;
	int out_col = 0;
	int cycles = 0;
	logic href_prev = 1'b0;
	logic [DPC_LATENCY-1:0] href_hist = '0;
	logic [DPC_LATENCY-1:0] vsync_hist = '0;
	string cur_name = "reset";

	`include "dpc_ref_model.svh"

	// one row per frame
	// defect line and column of -1 mean no defect
	string test_name [NUM_TESTS] = '{"hot_red", "cold_green", "cold_green_high_thr", "ramp",
		"thr_equal", "thr_below", "noise_a", "noise_b", "noise_c"};
	localparam int PAT [NUM_TESTS] = '{PAT_FLAT, PAT_FLAT, PAT_FLAT, PAT_RAMP, PAT_FLAT,
		PAT_FLAT, PAT_NOISE, PAT_NOISE, PAT_NOISE};
	localparam int BASE [NUM_TESTS] = '{40, 200, 200, 20, 100, 100, 100, 100, 100};
	localparam int THR [NUM_TESTS] = '{20, 20, 220, 0, 30, 29, 30, 60, 100};
	localparam int DEF_Y [NUM_TESTS] = '{4, 4, 4, -1, 6, 6, -1, -1, -1};
	localparam int DEF_X [NUM_TESTS] = '{4, 5, 5, -1, 6, 6, -1, -1, -1};
	localparam int DEF_VAL [NUM_TESTS] = '{250, 0, 0, 0, 130, 130, 0, 0, 0};
	// expected output at the defect and whether all else passes through
	localparam int EXP_DEF [NUM_TESTS] = '{40, 200, 0, -1, 130, 100, -1, -1, -1};
	localparam int THROUGH [NUM_TESTS] = '{1, 1, 1, 1, 1, 1, 0, 0, 0};

	isp_dpc dut0 (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.threshold (threshold),
		.in_href   (in_href),
		.in_vsync  (in_vsync),
		.in_raw    (in_raw),
		.out_href  (out_href),
		.out_vsync (out_vsync),
		.out_raw   (out_raw)
	);

	initial begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk;
	end

	task automatic check_value(input string label, input int exp, input int act);
		if (exp != act) begin
			$display("FAIL %s: expected %0d, actual %0d", label, exp, act);
			$display("Done: errors found");
			$fatal(1, "value mismatch in %s", label);
		end
	endtask

	// inputs change just after the rising edge
	task automatic step_clock();
		@(posedge pclk);
		#1;
	endtask

	task automatic send_frame();
		step_clock();
		in_vsync = 1'b1;
		step_clock();
		step_clock();
		in_vsync = 1'b0;
		for (int y = 0; y < FRAME_LINES; y++) begin
			for (int x = 0; x < LINE_WIDTH; x++) begin
				in_href = 1'b1;
				in_raw = pixel_t'(frame[y][x]);
				step_clock();
			end
			in_href = 1'b0;
			in_raw = '0;
			repeat (GAP_CYCLES) step_clock();
		end
	endtask

	// output at line y and column x holds input pixel (y-2, x-2)
	task automatic check_frame(input int t);
		int exp;
		string label;
		for (int y = 4; y < FRAME_LINES; y++) begin
			for (int x = 4; x < LINE_WIDTH; x++) begin
				label = $sformatf("%s line %0d col %0d", test_name[t], y, x);
				exp = expected_pixel(y - 2, x - 2, THR[t]);
				check_value(label, exp, captured[y][x]);
				if (THROUGH[t] != 0 && !(y - 2 == DEF_Y[t] && x - 2 == DEF_X[t])) begin
					check_value(label, frame[y-2][x-2], captured[y][x]);
				end
			end
		end
		if (EXP_DEF[t] >= 0) begin
			label = $sformatf("%s defect", test_name[t]);
			check_value(label, EXP_DEF[t], captured[DEF_Y[t] + 2][DEF_X[t] + 2]);
		end
	endtask

	// strobe delay, blanking and capture on the falling edge
	always @(negedge pclk) begin
		check_value({cur_name, " out_href"}, int'(href_hist[DPC_LATENCY-1]), int'(out_href));
		check_value({cur_name, " out_vsync"}, int'(vsync_hist[DPC_LATENCY-1]), int'(out_vsync));
		href_hist = {href_hist[DPC_LATENCY-2:0], in_href};
		vsync_hist = {vsync_hist[DPC_LATENCY-2:0], in_vsync};
		if (out_vsync) begin
			out_lines = 0;
			out_col = 0;
		end
		if (out_href) begin
			if (out_lines < FRAME_LINES && out_col < LINE_WIDTH) begin
				captured[out_lines][out_col] = int'(out_raw);
			end
			out_col++;
		end else begin
			check_value({cur_name, " out_raw blanking"}, 0, int'(out_raw));
			// falling href closes a line
			if (href_prev) begin
				out_lines++;
				out_col = 0;
			end
		end
		href_prev = out_href;
	end

	always @(posedge pclk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Done: errors found");
			$fatal(1, "timeout, output frames still incomplete after %0d cycles", cycles);
		end
	end

	initial begin
		void'($urandom(85));
		rst_n = 1'b0;
		threshold = '0;
		in_href = 1'b0;
		in_vsync = 1'b0;
		in_raw = '0;
		repeat (8) @(posedge pclk);
		#1;
		rst_n = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_name = test_name[t];
			build_frame(PAT[t], BASE[t], DEF_Y[t], DEF_X[t], DEF_VAL[t]);
			step_clock();
			threshold = pixel_t'(THR[t]);
			send_frame();
			// last output line arrives DPC_LATENCY after the input
			wait (out_lines == FRAME_LINES);
			check_frame(t);
		end
		$display("Done: no errors");
		$finish;
	end
endmodule

//--- isp_dpc.f
+incdir+bench
source/isp_dpc_pkg.sv
source/dpc_window_if.sv
source/dpc_line_buffer.sv
source/dpc_window.sv
source/dpc_median.sv
source/dpc_detect.sv
source/isp_dpc.sv
bench/tb_isp_dpc.sv

//--- Makefile
# Verilator build and run of the DPC testbench

SIM := obj_dir/Vtb_isp_dpc
SRCS := $(wildcard source/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): isp_dpc.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_isp_dpc -f isp_dpc.f

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
